// ==== hw/video_pkg.sv ====
package video_pkg;

	// bus and pixel widths
	localparam int ADDR_W  = 8;
	localparam int DATA_W  = 32;
	localparam int COORD_W = 12;
	localparam int LED_W   = 4;

	typedef logic [ADDR_W-1:0]  reg_addr_t;
	typedef logic [DATA_W-1:0]  reg_data_t;
	typedef logic [COORD_W-1:0] coord_t;
	typedef logic [LED_W-1:0]   led_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb888_t;

	// --------------------------------------------------
	// register map, word addresses
	// --------------------------------------------------
	localparam reg_addr_t REG_CTL         = 8'h00;
	localparam reg_addr_t REG_HTOTAL      = 8'h01;
	localparam reg_addr_t REG_HDISP_START = 8'h02;
	localparam reg_addr_t REG_HDISP_END   = 8'h03;
	localparam reg_addr_t REG_HSYNC_END   = 8'h04;
	localparam reg_addr_t REG_VTOTAL      = 8'h05;
	localparam reg_addr_t REG_VDISP_START = 8'h06;
	localparam reg_addr_t REG_VDISP_END   = 8'h07;
	localparam reg_addr_t REG_VSYNC_END   = 8'h08;
	localparam reg_addr_t REG_LED         = 8'h10;

	// small default raster for simulation
	localparam int DEF_H_ACTIVE = 32;
	localparam int DEF_V_ACTIVE = 8;
	localparam int DEF_H_FRONT  = 4;
	localparam int DEF_H_SYNC   = 6;
	localparam int DEF_H_BACK   = 6;
	localparam int DEF_V_FRONT  = 1;
	localparam int DEF_V_SYNC   = 2;
	localparam int DEF_V_BACK   = 2;

endpackage

// ==== hw/video_ctrl_regs.sv ====
module video_ctrl_regs #(
	parameter video_pkg::coord_t INIT_HTOTAL      = 12'd48,
	parameter video_pkg::coord_t INIT_HDISP_START = 12'd12,
	parameter video_pkg::coord_t INIT_HDISP_END   = 12'd44,
	parameter video_pkg::coord_t INIT_HSYNC_END   = 12'd6,
	parameter video_pkg::coord_t INIT_VTOTAL      = 12'd13,
	parameter video_pkg::coord_t INIT_VDISP_START = 12'd4,
	parameter video_pkg::coord_t INIT_VDISP_END   = 12'd12,
	parameter video_pkg::coord_t INIT_VSYNC_END   = 12'd2
) (
	input  logic                 peri_aclk,
	input  logic                 peri_aresetn,
	input  logic                 bus_stb_i,
	input  logic                 bus_we_i,
	input  video_pkg::reg_addr_t bus_adr_i,
	input  video_pkg::reg_data_t bus_dat_i,
	output video_pkg::reg_data_t bus_dat_o,
	output logic                 bus_ack_o,
	output logic                 enable_o,
	output video_pkg::coord_t    htotal_o,
	output video_pkg::coord_t    hdisp_start_o,
	output video_pkg::coord_t    hdisp_end_o,
	output video_pkg::coord_t    hsync_end_o,
	output video_pkg::coord_t    vtotal_o,
	output video_pkg::coord_t    vdisp_start_o,
	output video_pkg::coord_t    vdisp_end_o,
	output video_pkg::coord_t    vsync_end_o,
	output video_pkg::led_t      led_o
);
	import video_pkg::*;

	logic      wr_en;
	reg_data_t rd_data;

	assign wr_en = bus_stb_i && bus_we_i;

	// --------------------------------------------------
	// register write
	// --------------------------------------------------
	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			enable_o      <= 1'b0;
			htotal_o      <= INIT_HTOTAL;
			hdisp_start_o <= INIT_HDISP_START;
			hdisp_end_o   <= INIT_HDISP_END;
			hsync_end_o   <= INIT_HSYNC_END;
			vtotal_o      <= INIT_VTOTAL;
			vdisp_start_o <= INIT_VDISP_START;
			vdisp_end_o   <= INIT_VDISP_END;
			vsync_end_o   <= INIT_VSYNC_END;
			led_o         <= '0;
		end else if (wr_en) begin
			case (bus_adr_i)
				REG_CTL:         enable_o      <= bus_dat_i[0];
				REG_HTOTAL:      htotal_o      <= bus_dat_i[COORD_W-1:0];
				REG_HDISP_START: hdisp_start_o <= bus_dat_i[COORD_W-1:0];
				REG_HDISP_END:   hdisp_end_o   <= bus_dat_i[COORD_W-1:0];
				REG_HSYNC_END:   hsync_end_o   <= bus_dat_i[COORD_W-1:0];
				REG_VTOTAL:      vtotal_o      <= bus_dat_i[COORD_W-1:0];
				REG_VDISP_START: vdisp_start_o <= bus_dat_i[COORD_W-1:0];
				REG_VDISP_END:   vdisp_end_o   <= bus_dat_i[COORD_W-1:0];
				REG_VSYNC_END:   vsync_end_o   <= bus_dat_i[COORD_W-1:0];
				REG_LED:         led_o         <= bus_dat_i[LED_W-1:0];
				default: ;
			endcase
		end
	end

	// --------------------------------------------------
	// read mux and acknowledge
	// --------------------------------------------------
	// unmapped words read as zero
	always_comb begin
		case (bus_adr_i)
			REG_CTL:         rd_data = reg_data_t'(enable_o);
			REG_HTOTAL:      rd_data = reg_data_t'(htotal_o);
			REG_HDISP_START: rd_data = reg_data_t'(hdisp_start_o);
			REG_HDISP_END:   rd_data = reg_data_t'(hdisp_end_o);
			REG_HSYNC_END:   rd_data = reg_data_t'(hsync_end_o);
			REG_VTOTAL:      rd_data = reg_data_t'(vtotal_o);
			REG_VDISP_START: rd_data = reg_data_t'(vdisp_start_o);
			REG_VDISP_END:   rd_data = reg_data_t'(vdisp_end_o);
			REG_VSYNC_END:   rd_data = reg_data_t'(vsync_end_o);
			REG_LED:         rd_data = reg_data_t'(led_o);
			default:         rd_data = '0;
		endcase
	end

	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			bus_ack_o <= 1'b0;
		end else begin
			bus_ack_o <= bus_stb_i;
		end
	end

	// read data only matters with the ack
	always_ff @(posedge peri_aclk) begin
		if (bus_stb_i) begin
			bus_dat_o <= rd_data;
		end
	end

	// host waits for the ack before the next request
	a_no_stb_before_ack: assert property (
		@(posedge peri_aclk) disable iff (!peri_aresetn)
		bus_stb_i |=> !bus_stb_i
	) else $error("bus strobe issued while acknowledge pending");

endmodule

// ==== hw/video_timing_gen.sv ====
module video_timing_gen (
	input  logic              peri_aclk,
	input  logic              peri_aresetn,
	input  logic              enable_i,
	input  video_pkg::coord_t htotal_i,
	input  video_pkg::coord_t hdisp_start_i,
	input  video_pkg::coord_t hdisp_end_i,
	input  video_pkg::coord_t hsync_end_i,
	input  video_pkg::coord_t vtotal_i,
	input  video_pkg::coord_t vdisp_start_i,
	input  video_pkg::coord_t vdisp_end_i,
	input  video_pkg::coord_t vsync_end_i,
	output logic              hsync_o,
	output logic              vsync_o,
	output logic              de_o,
	output video_pkg::coord_t x_o,
	output video_pkg::coord_t y_o,
	output logic [7:0]        frame_o
);
	import video_pkg::*;

	// working copy of the configuration for the current frame
	logic       run_q;
	coord_t     htotal_q;
	coord_t     hdisp_start_q;
	coord_t     hdisp_end_q;
	coord_t     hsync_end_q;
	coord_t     vtotal_q;
	coord_t     vdisp_start_q;
	coord_t     vdisp_end_q;
	coord_t     vsync_end_q;

	coord_t     h_cnt;
	coord_t     v_cnt;
	logic [7:0] frame_cnt;

	logic       h_last;
	logic       v_last;
	logic       frame_next;
	logic       h_act;
	logic       v_act;

	assign h_last = (h_cnt == htotal_q - 1'b1);
	assign v_last = (v_cnt == vtotal_q - 1'b1);

	// counters are about to sit at 0,0
	assign frame_next = !run_q || (h_last && v_last);

	assign h_act = (h_cnt >= hdisp_start_q) && (h_cnt < hdisp_end_q);
	assign v_act = (v_cnt >= vdisp_start_q) && (v_cnt < vdisp_end_q);

	// --------------------------------------------------
	// frame start latch
	// --------------------------------------------------
	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			run_q <= 1'b0;
		end else if (frame_next) begin
			run_q <= enable_i;
		end
	end

	always_ff @(posedge peri_aclk) begin
		if (frame_next) begin
			htotal_q      <= htotal_i;
			hdisp_start_q <= hdisp_start_i;
			hdisp_end_q   <= hdisp_end_i;
			hsync_end_q   <= hsync_end_i;
			vtotal_q      <= vtotal_i;
			vdisp_start_q <= vdisp_start_i;
			vdisp_end_q   <= vdisp_end_i;
			vsync_end_q   <= vsync_end_i;
		end
	end

	// --------------------------------------------------
	// raster counters
	// --------------------------------------------------
	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn || !run_q) begin
			h_cnt     <= '0;
			v_cnt     <= '0;
			frame_cnt <= '0;
		end else if (h_last) begin
			h_cnt <= '0;
			if (v_last) begin
				v_cnt     <= '0;
				frame_cnt <= frame_cnt + 1'b1;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// registered outputs, syncs idle high when stopped
	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn || !run_q) begin
			hsync_o <= 1'b1;
			vsync_o <= 1'b1;
			de_o    <= 1'b0;
		end else begin
			hsync_o <= !(h_cnt < hsync_end_q);
			vsync_o <= !(v_cnt < vsync_end_q);
			de_o    <= h_act && v_act;
		end
	end

	always_ff @(posedge peri_aclk) begin
		x_o     <= h_cnt - hdisp_start_q;
		y_o     <= v_cnt - vdisp_start_q;
		frame_o <= frame_cnt;
	end

	a_geom_order: assert property (
		@(posedge peri_aclk) disable iff (!peri_aresetn)
		run_q |-> (hdisp_start_q < hdisp_end_q) && (hdisp_start_q < htotal_q)
			&& (vdisp_start_q < vdisp_end_q) && (vdisp_start_q < vtotal_q)
	) else $error("latched display window start not below end and total");

endmodule

// ==== hw/pattern_source.sv ====
module pattern_source (
	input  logic               peri_aclk,
	input  logic               peri_aresetn,
	input  logic               hsync_i,
	input  logic               vsync_i,
	input  logic               de_i,
	input  video_pkg::coord_t  x_i,
	input  video_pkg::coord_t  y_i,
	input  logic [7:0]         frame_i,
	output logic               hsync_o,
	output logic               vsync_o,
	output logic               de_o,
	output video_pkg::rgb888_t pixel_o
);
	import video_pkg::*;

	rgb888_t colour;

	// x ramp on red, y ramp on green, frame count on blue
	always_comb begin
		colour = '0;
		if (de_i) begin
			colour.r = x_i[7:0];
			colour.g = y_i[7:0];
			colour.b = frame_i;
		end
	end

	// --------------------------------------------------
	// pipeline stage
	// --------------------------------------------------
	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			hsync_o <= 1'b1;
			vsync_o <= 1'b1;
			de_o    <= 1'b0;
		end else begin
			hsync_o <= hsync_i;
			vsync_o <= vsync_i;
			de_o    <= de_i;
		end
	end

	always_ff @(posedge peri_aclk) begin
		pixel_o <= colour;
	end

endmodule

// ==== hw/vga_out.sv ====
module vga_out (
	input  logic               peri_aclk,
	input  logic               peri_aresetn,
	input  logic               hsync_i,
	input  logic               vsync_i,
	input  logic               de_i,
	input  video_pkg::rgb888_t pixel_i,
	output logic               vga_hsync_o,
	output logic               vga_vsync_o,
	output logic               vga_de_o,
	output logic [4:0]         vga_r_o,
	output logic [5:0]         vga_g_o,
	output logic [4:0]         vga_b_o
);

	// --------------------------------------------------
	// pin registers
	// --------------------------------------------------
	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			vga_hsync_o <= 1'b1;
			vga_vsync_o <= 1'b1;
			vga_de_o    <= 1'b0;
		end else begin
			vga_hsync_o <= hsync_i;
			vga_vsync_o <= vsync_i;
			vga_de_o    <= de_i;
		end
	end

	// 5/6/5 keeps the top bits of each field
	always_ff @(posedge peri_aclk) begin
		vga_r_o <= pixel_i.r[7:3];
		vga_g_o <= pixel_i.g[7:2];
		vga_b_o <= pixel_i.b[7:3];
	end

endmodule

// ==== hw/video_top.sv ====
module video_top #(
	parameter int H_ACTIVE = video_pkg::DEF_H_ACTIVE,
	parameter int V_ACTIVE = video_pkg::DEF_V_ACTIVE
) (
	input  logic                 peri_aclk,
	input  logic                 peri_aresetn,
	input  logic                 bus_stb_i,
	input  logic                 bus_we_i,
	input  video_pkg::reg_addr_t bus_adr_i,
	input  video_pkg::reg_data_t bus_dat_i,
	output video_pkg::reg_data_t bus_dat_o,
	output logic                 bus_ack_o,
	output video_pkg::led_t      led_o,
	output logic                 vga_hsync_o,
	output logic                 vga_vsync_o,
	output logic                 vga_de_o,
	output logic [4:0]           vga_r_o,
	output logic [5:0]           vga_g_o,
	output logic [4:0]           vga_b_o
);
	import video_pkg::*;

	// line is sync, back porch, active, front porch
	localparam coord_t INIT_HSYNC_END   = coord_t'(DEF_H_SYNC);
	localparam coord_t INIT_HDISP_START = coord_t'(DEF_H_SYNC + DEF_H_BACK);
	localparam coord_t INIT_HDISP_END   = coord_t'(DEF_H_SYNC + DEF_H_BACK + H_ACTIVE);
	localparam coord_t INIT_HTOTAL      =
		coord_t'(DEF_H_SYNC + DEF_H_BACK + H_ACTIVE + DEF_H_FRONT);
	localparam coord_t INIT_VSYNC_END   = coord_t'(DEF_V_SYNC);
	localparam coord_t INIT_VDISP_START = coord_t'(DEF_V_SYNC + DEF_V_BACK);
	localparam coord_t INIT_VDISP_END   = coord_t'(DEF_V_SYNC + DEF_V_BACK + V_ACTIVE);
	localparam coord_t INIT_VTOTAL      =
		coord_t'(DEF_V_SYNC + DEF_V_BACK + V_ACTIVE + DEF_V_FRONT);

	logic       enable;
	coord_t     htotal;
	coord_t     hdisp_start;
	coord_t     hdisp_end;
	coord_t     hsync_end;
	coord_t     vtotal;
	coord_t     vdisp_start;
	coord_t     vdisp_end;
	coord_t     vsync_end;

	// timing stage outputs
	logic       tg_hsync;
	logic       tg_vsync;
	logic       tg_de;
	coord_t     tg_x;
	coord_t     tg_y;
	logic [7:0] tg_frame;

	// pattern stage outputs
	logic       pat_hsync;
	logic       pat_vsync;
	logic       pat_de;
	rgb888_t    pat_pixel;

	// --------------------------------------------------
	// register block
	// --------------------------------------------------
	video_ctrl_regs #(
		.INIT_HTOTAL      (INIT_HTOTAL),
		.INIT_HDISP_START (INIT_HDISP_START),
		.INIT_HDISP_END   (INIT_HDISP_END),
		.INIT_HSYNC_END   (INIT_HSYNC_END),
		.INIT_VTOTAL      (INIT_VTOTAL),
		.INIT_VDISP_START (INIT_VDISP_START),
		.INIT_VDISP_END   (INIT_VDISP_END),
		.INIT_VSYNC_END   (INIT_VSYNC_END)
	) u_regs (
		.peri_aclk     (peri_aclk),
		.peri_aresetn  (peri_aresetn),
		.bus_stb_i     (bus_stb_i),
		.bus_we_i      (bus_we_i),
		.bus_adr_i     (bus_adr_i),
		.bus_dat_i     (bus_dat_i),
		.bus_dat_o     (bus_dat_o),
		.bus_ack_o     (bus_ack_o),
		.enable_o      (enable),
		.htotal_o      (htotal),
		.hdisp_start_o (hdisp_start),
		.hdisp_end_o   (hdisp_end),
		.hsync_end_o   (hsync_end),
		.vtotal_o      (vtotal),
		.vdisp_start_o (vdisp_start),
		.vdisp_end_o   (vdisp_end),
		.vsync_end_o   (vsync_end),
		.led_o         (led_o)
	);

	// --------------------------------------------------
	// pixel pipeline, one register per stage
	// --------------------------------------------------
	video_timing_gen u_timing (
		.peri_aclk     (peri_aclk),
		.peri_aresetn  (peri_aresetn),
		.enable_i      (enable),
		.htotal_i      (htotal),
		.hdisp_start_i (hdisp_start),
		.hdisp_end_i   (hdisp_end),
		.hsync_end_i   (hsync_end),
		.vtotal_i      (vtotal),
		.vdisp_start_i (vdisp_start),
		.vdisp_end_i   (vdisp_end),
		.vsync_end_i   (vsync_end),
		.hsync_o       (tg_hsync),
		.vsync_o       (tg_vsync),
		.de_o          (tg_de),
		.x_o           (tg_x),
		.y_o           (tg_y),
		.frame_o       (tg_frame)
	);

	pattern_source u_pattern (
		.peri_aclk    (peri_aclk),
		.peri_aresetn (peri_aresetn),
		.hsync_i      (tg_hsync),
		.vsync_i      (tg_vsync),
		.de_i         (tg_de),
		.x_i          (tg_x),
		.y_i          (tg_y),
		.frame_i      (tg_frame),
		.hsync_o      (pat_hsync),
		.vsync_o      (pat_vsync),
		.de_o         (pat_de),
		.pixel_o      (pat_pixel)
	);

	vga_out u_vga (
		.peri_aclk    (peri_aclk),
		.peri_aresetn (peri_aresetn),
		.hsync_i      (pat_hsync),
		.vsync_i      (pat_vsync),
		.de_i         (pat_de),
		.pixel_i      (pat_pixel),
		.vga_hsync_o  (vga_hsync_o),
		.vga_vsync_o  (vga_vsync_o),
		.vga_de_o     (vga_de_o),
		.vga_r_o      (vga_r_o),
		.vga_g_o      (vga_g_o),
		.vga_b_o      (vga_b_o)
	);

endmodule

// ==== bench/tb_video_top.sv ====
module tb_video_top;
	timeunit 1ns;
	timeprecision 1ps;
	import video_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DLY  = 10;
	localparam int RST_CYCLES = 16;
	localparam int TD_WORDS   = 3 * 64;

	localparam logic [31:0] CMD_WRITE  = 32'd1;
	localparam logic [31:0] CMD_READ   = 32'd2;
	localparam logic [31:0] CMD_FRAMES = 32'd3;
	localparam logic [31:0] CMD_STAGE  = 32'd4;
	localparam logic [31:0] CMD_MID    = 32'd5;
	localparam logic [31:0] CMD_IDLE   = 32'd6;

	logic       peri_aclk = 1'b0;
	logic       peri_aresetn;
	logic       bus_stb_i;
	logic       bus_we_i;
	reg_addr_t  bus_adr_i;
	reg_data_t  bus_dat_i;
	reg_data_t  bus_dat_o;
	logic       bus_ack_o;
	led_t       led_o;
	logic       vga_hsync_o;
	logic       vga_vsync_o;
	logic       vga_de_o;
	logic [4:0] vga_r_o;
	logic [5:0] vga_g_o;
	logic [4:0] vga_b_o;

	logic [31:0] td [0:TD_WORDS-1];

	// expected register state, and the geometry of the frame on the pins
	coord_t      shadow [1:8];
	coord_t      fgeom [1:8];
	led_t        led_exp;
	logic        en_exp;
	int          fall_count;
	logic [7:0]  frame_idx;
	reg_addr_t   stage_adr [$];
	reg_data_t   stage_dat [$];
	logic        checking;
	int          limit_cycles = 0;

	// pin samples taken at the falling edge
	logic        hs = 1'b1;
	logic        vs = 1'b1;
	logic        de = 1'b0;
	logic        hs_prev = 1'b1;
	logic        vs_prev = 1'b1;
	logic        de_prev = 1'b0;
	logic [4:0]  r_smp;
	logic [5:0]  g_smp;
	logic [4:0]  b_smp;
	event        sampled;

	video_top #(
		.H_ACTIVE (DEF_H_ACTIVE),
		.V_ACTIVE (DEF_V_ACTIVE)
	) i_dut (
		.peri_aclk    (peri_aclk),
		.peri_aresetn (peri_aresetn),
		.bus_stb_i    (bus_stb_i),
		.bus_we_i     (bus_we_i),
		.bus_adr_i    (bus_adr_i),
		.bus_dat_i    (bus_dat_i),
		.bus_dat_o    (bus_dat_o),
		.bus_ack_o    (bus_ack_o),
		.led_o        (led_o),
		.vga_hsync_o  (vga_hsync_o),
		.vga_vsync_o  (vga_vsync_o),
		.vga_de_o     (vga_de_o),
		.vga_r_o      (vga_r_o),
		.vga_g_o      (vga_g_o),
		.vga_b_o      (vga_b_o)
	);

	always #(CLK_PERIOD / 2) peri_aclk = ~peri_aclk;

	function automatic logic fell(input logic was, input logic now);
		return (was === 1'b1) && (now === 1'b0);
	endfunction

	function automatic logic rose(input logic was, input logic now);
		return (was === 1'b0) && (now === 1'b1);
	endfunction

	// --------------------------------------------------
	// raster monitor
	// --------------------------------------------------
	always @(negedge peri_aclk) begin
		hs_prev = hs;
		vs_prev = vs;
		de_prev = de;
		hs = vga_hsync_o;
		vs = vga_vsync_o;
		de = vga_de_o;
		r_smp = vga_r_o;
		g_smp = vga_g_o;
		b_smp = vga_b_o;
		// new frame, keep its geometry and index
		if (fell(vs_prev, vs)) begin
			fgeom = shadow;
			frame_idx = fall_count[7:0];
			fall_count++;
		end
		-> sampled;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge peri_aclk);
		report_fail($sformatf("timeout, run still busy after %0d clock cycles", limit_cycles));
	end

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	task automatic report_fail(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_reg(input string name, input reg_data_t got, input reg_data_t exp);
		if (got !== exp) begin
			report_fail($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input coord_t got, input coord_t exp);
		if (got !== exp) begin
			report_fail($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_led(input led_t got, input led_t exp);
		if (got !== exp) begin
			report_fail($sformatf("ERROR led_o got 0x%h expected 0x%h", got, exp));
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_fail($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// pins carry the top bits of each field
	task automatic check_pixel(input logic [4:0] r, input logic [5:0] g, input logic [4:0] b,
		input rgb888_t exp);
		if (r !== exp.r[7:3]) begin
			report_fail($sformatf("ERROR vga_r_o got 0x%h expected 0x%h", r, exp.r[7:3]));
		end
		if (g !== exp.g[7:2]) begin
			report_fail($sformatf("ERROR vga_g_o got 0x%h expected 0x%h", g, exp.g[7:2]));
		end
		if (b !== exp.b[7:3]) begin
			report_fail($sformatf("ERROR vga_b_o got 0x%h expected 0x%h", b, exp.b[7:3]));
		end
	endtask

	// --------------------------------------------------
	// bus access
	// --------------------------------------------------
	task automatic note_write(input reg_addr_t adr, input reg_data_t dat);
		if (adr >= REG_HTOTAL && adr <= REG_VSYNC_END) begin
			shadow[adr] = dat[COORD_W-1:0];
		end else if (adr == REG_LED) begin
			led_exp = dat[LED_W-1:0];
		end else if (adr == REG_CTL) begin
			// frame numbering restarts at enable
			if (!en_exp && dat[0]) begin
				fall_count = 0;
			end
			en_exp = dat[0];
		end
	endtask

	task automatic bus_op(input logic we, input reg_addr_t adr, input reg_data_t dat,
		output reg_data_t rdata);
		@(posedge peri_aclk);
		#DRIVE_DLY;
		bus_stb_i = 1'b1;
		bus_we_i = we;
		bus_adr_i = adr;
		bus_dat_i = dat;
		@(posedge peri_aclk);
		#DRIVE_DLY;
		bus_stb_i = 1'b0;
		bus_we_i = 1'b0;
		if (we) begin
			note_write(adr, dat);
		end
		@(negedge peri_aclk);
		if (bus_ack_o !== 1'b1) begin
			report_fail("no bus acknowledge one cycle after the strobe");
		end
		rdata = bus_dat_o;
		if (we && adr == REG_LED) begin
			check_led(led_o, led_exp);
		end
		@(negedge peri_aclk);
		if (bus_ack_o !== 1'b0) begin
			report_fail("bus acknowledge lasted more than one cycle");
		end
	endtask

	task automatic check_idle();
		@(negedge peri_aclk);
		check_level("vga_hsync_o", vga_hsync_o, 1'b1);
		check_level("vga_vsync_o", vga_vsync_o, 1'b1);
		check_level("vga_de_o", vga_de_o, 1'b0);
		check_pixel(vga_r_o, vga_g_o, vga_b_o, '0);
		check_led(led_o, led_exp);
	endtask

	// --------------------------------------------------
	// frame checks
	// --------------------------------------------------
	task automatic wait_vsync_fall();
		do begin
			@(sampled);
		end while (!fell(vs_prev, vs));
	endtask

	// starts on the vsync fall sample, ends on the next one
	task automatic check_frame();
		coord_t     geo [1:8];
		logic [7:0] fi;
		coord_t     since_hfall;
		coord_t     hs_low;
		coord_t     de_run;
		coord_t     x;
		coord_t     y;
		coord_t     lines;
		coord_t     vs_lines;
		coord_t     de_lines;
		logic       have_hfall;
		rgb888_t    exp;
		geo = fgeom;
		fi = frame_idx;
		since_hfall = '0;
		hs_low = '0;
		de_run = '0;
		x = '0;
		y = '0;
		lines = '0;
		vs_lines = '0;
		de_lines = '0;
		have_hfall = 1'b0;
		do begin
			since_hfall++;
			if (fell(hs_prev, hs)) begin
				if (have_hfall) begin
					check_count("hsync period", since_hfall, geo[REG_HTOTAL]);
				end
				since_hfall = '0;
				have_hfall = 1'b1;
				lines++;
				if (!vs) begin
					vs_lines++;
				end
			end
			if (!hs) begin
				hs_low++;
			end
			if (rose(hs_prev, hs)) begin
				check_count("hsync low width", hs_low, geo[REG_HSYNC_END]);
				hs_low = '0;
			end
			if (rose(vs_prev, vs)) begin
				check_count("vsync low lines", vs_lines, geo[REG_VSYNC_END]);
				check_count("vsync rise offset from hsync fall", since_hfall, '0);
			end
			if (fell(de_prev, de)) begin
				check_count("de width", de_run, geo[REG_HDISP_END] - geo[REG_HDISP_START]);
			end
			if (rose(de_prev, de)) begin
				check_count("de delay after hsync fall", since_hfall, geo[REG_HDISP_START]);
				x = '0;
				y = de_lines;
				de_lines++;
				de_run = '0;
			end
			exp = '0;
			if (de) begin
				exp.r = x[7:0];
				exp.g = y[7:0];
				exp.b = fi;
				x++;
				de_run++;
			end
			check_pixel(r_smp, g_smp, b_smp, exp);
			@(sampled);
		end while (!fell(vs_prev, vs));
		check_count("vsync period in lines", lines, geo[REG_VTOTAL]);
		check_count("de lines per frame", de_lines, geo[REG_VDISP_END] - geo[REG_VDISP_START]);
	endtask

	// the first frame after a write may still be in flight, so skip it
	task automatic check_frames(input int n);
		wait_vsync_fall();
		wait_vsync_fall();
		checking = 1'b1;
		repeat (n) check_frame();
		checking = 1'b0;
	endtask

	task automatic apply_staged();
		reg_data_t unused;
		wait (checking);
		// two lines into the frame
		repeat (2 * fgeom[REG_HTOTAL]) @(posedge peri_aclk);
		while (stage_adr.size() > 0) begin
			bus_op(1'b1, stage_adr.pop_front(), stage_dat.pop_front(), unused);
		end
	endtask

	// --------------------------------------------------
	// setup
	// --------------------------------------------------
	// line is sync, back porch, active, front porch
	task automatic init_shadow();
		shadow[REG_HSYNC_END]   = coord_t'(DEF_H_SYNC);
		shadow[REG_HDISP_START] = coord_t'(DEF_H_SYNC + DEF_H_BACK);
		shadow[REG_HDISP_END]   = coord_t'(DEF_H_SYNC + DEF_H_BACK + DEF_H_ACTIVE);
		shadow[REG_HTOTAL]      = coord_t'(DEF_H_SYNC + DEF_H_BACK + DEF_H_ACTIVE + DEF_H_FRONT);
		shadow[REG_VSYNC_END]   = coord_t'(DEF_V_SYNC);
		shadow[REG_VDISP_START] = coord_t'(DEF_V_SYNC + DEF_V_BACK);
		shadow[REG_VDISP_END]   = coord_t'(DEF_V_SYNC + DEF_V_BACK + DEF_V_ACTIVE);
		shadow[REG_VTOTAL]      = coord_t'(DEF_V_SYNC + DEF_V_BACK + DEF_V_ACTIVE + DEF_V_FRONT);
		fgeom = shadow;
	endtask

	// cycle budget from the test data, frames sized by the largest raster seen
	function automatic int run_length();
		int    i;
		int    ops;
		longint cyc;
		longint ht;
		longint vt;
		longint frame_max;
		ops = 0;
		cyc = 0;
		ht = shadow[REG_HTOTAL];
		vt = shadow[REG_VTOTAL];
		frame_max = ht * vt;
		for (i = 0; i + 2 < TD_WORDS; i += 3) begin
			if ($isunknown(td[i]) || td[i] == 0) begin
				break;
			end
			if (td[i] == CMD_WRITE || td[i] == CMD_STAGE) begin
				if (td[i+1] == REG_HTOTAL) begin
					ht = td[i+2][COORD_W-1:0];
				end
				if (td[i+1] == REG_VTOTAL) begin
					vt = td[i+2][COORD_W-1:0];
				end
				if (ht * vt > frame_max) begin
					frame_max = ht * vt;
				end
			end
			if (td[i] == CMD_FRAMES || td[i] == CMD_MID) begin
				cyc += (td[i+2] + 2) * frame_max;
			end else begin
				ops++;
			end
		end
		return int'(2 * (RST_CYCLES + 4 * ops + cyc) + 1000);
	endfunction

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		reg_data_t   rdata;
		reg_addr_t   adr;
		logic [31:0] cmd;
		int          pc;
		peri_aresetn = 1'b0;
		bus_stb_i = 1'b0;
		bus_we_i = 1'b0;
		bus_adr_i = '0;
		bus_dat_i = '0;
		checking = 1'b0;
		en_exp = 1'b0;
		led_exp = '0;
		fall_count = 0;
		frame_idx = '0;
		init_shadow();
		$readmemh("bench/video_testdata.txt", td);
		limit_cycles = run_length();
		repeat (RST_CYCLES) @(posedge peri_aclk);
		#DRIVE_DLY;
		peri_aresetn = 1'b1;
		check_idle();
		pc = 0;
		while (pc + 2 < TD_WORDS && !$isunknown(td[pc]) && td[pc] != 0) begin
			cmd = td[pc];
			adr = td[pc+1][ADDR_W-1:0];
			case (cmd)
				CMD_WRITE: bus_op(1'b1, adr, td[pc+2], rdata);
				CMD_READ: begin
					bus_op(1'b0, adr, '0, rdata);
					check_reg($sformatf("bus_dat_o at 0x%h", adr), rdata, td[pc+2]);
				end
				CMD_FRAMES: check_frames(td[pc+2]);
				CMD_STAGE: begin
					stage_adr.push_back(adr);
					stage_dat.push_back(td[pc+2]);
				end
				CMD_MID: begin
					fork
						check_frames(td[pc+2]);
						apply_staged();
					join
				end
				CMD_IDLE: check_idle();
				default: report_fail($sformatf("unknown command %0h in test data entry %0d",
					cmd, pc / 3));
			endcase
			pc += 3;
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== files.f ====
hw/video_pkg.sv
hw/video_ctrl_regs.sv
hw/video_timing_gen.sv
hw/pattern_source.sv
hw/vga_out.sv
hw/video_top.sv
bench/tb_video_top.sv

// ==== bench/video_testdata.txt ====
// three hex words per entry: command, word address, data
// 1 write, 2 read and compare, 3 check frames, 4 stage a write,
// 5 check frames with staged writes in the first frame, 6 check idle pins
// reset geometry
2 01 00000030
2 02 0000000c
2 03 0000002c
2 04 00000006
2 05 0000000d
2 06 00000004
2 07 0000000c
2 08 00000002
2 00 00000000
// leds while the raster is off
1 10 00000005
2 10 00000005
6 00 00000000
// unmapped words
2 09 00000000
2 20 00000000
2 ff 00000000
// run the reset geometry
1 00 00000001
2 00 00000001
3 00 00000003
// set a
1 01 00000028
1 02 0000000a
1 03 00000022
1 04 00000004
1 05 0000000a
1 06 00000005
1 07 00000009
1 08 00000003
3 00 00000003
2 01 00000028
2 02 0000000a
2 03 00000022
2 04 00000004
2 05 0000000a
2 06 00000005
2 07 00000009
2 08 00000003
// set b, written in the middle of a frame
4 01 00000040
4 02 00000010
4 03 00000038
4 04 00000008
4 05 0000000e
4 06 00000003
4 07 0000000d
4 08 00000001
4 10 0000000a
5 00 00000003
2 01 00000040
2 05 0000000e
2 10 0000000a
3 00 00000002
